//--- hw/gamepad_pkg.sv
// shared widths, vector types, poller states and timing defaults for the gamepad front end
`default_nettype none

package gamepad_pkg;

    // button counts per pad
    localparam int NES_BITS  = 8;
    localparam int SNES_BITS = 12;   // fixed by the snes protocol

    // nes buttons, pressed = 1
    // bit 7 down to 0: a, b, select, start, up, down, left, right
    typedef logic [NES_BITS-1:0] nes_buttons_t;

    // snes frame in serial order, first bit shifted in lands at bit 11
    // b, y, select, start, up, down, left, right, a, x, l, r
    typedef logic [SNES_BITS-1:0] snes_frame_t;

    // nes poller timing counter, holds up to 2047 cycles
    typedef logic [10:0] cycle_count_t;

    // nes poller states
    typedef enum logic [1:0] {
        latch_pulse,   // latch held high
        read_a,        // a bit already on the data pin, clock idle low
        read_shift     // one clock slot per remaining button
    } nes_state_t;

    // 64 MHz system clock
    localparam cycle_count_t LATCH_CYCLES_DEFAULT = 11'd768;  // 12 us latch and bit period
    localparam cycle_count_t HALF_CYCLES_DEFAULT  = 11'd384;  // 6 us half period

    // snes decode
    localparam snes_frame_t SNES_NONE = '1;   // idle pmod line, no pad attached
    localparam int SNES_MAX_PRESSED   = 2;    // more than this is a corrupt frame

endpackage

`default_nettype wire

//--- hw/gamepad_top.sv
// gamepad front end top, nes poller plus snes pmod path with snes taking priority when present
`default_nettype none

module gamepad_top #(
    parameter gamepad_pkg::cycle_count_t latch_cycles = gamepad_pkg::LATCH_CYCLES_DEFAULT,
    parameter gamepad_pkg::cycle_count_t half_cycles  = gamepad_pkg::HALF_CYCLES_DEFAULT
) (
    input  logic clk,
    input  logic rst_n,

    // nes 7-pin port
    input  logic nes_data,
    output logic nes_latch,
    output logic nes_clk,

    // snes gamepad pmod
    input  logic pmod_data,
    input  logic pmod_clk,
    input  logic pmod_latch,

    // buttons shared by both pads
    output logic a,
    output logic b,
    output logic select,
    output logic start,
    output logic up,
    output logic down,
    output logic left,
    output logic right,

    // snes only
    output logic x,
    output logic y,
    output logic l,
    output logic r,

    output logic snes_active   // 1 = snes pad in use, 0 = nes
);

    gamepad_pkg::nes_buttons_t nes_buttons;
    gamepad_pkg::snes_frame_t  frame;
    gamepad_pkg::snes_frame_t  snes_buttons;
    logic                      is_present;

    nes_poller #(
        .latch_cycles (latch_cycles),
        .half_cycles  (half_cycles)
    ) u_nes_poller (
        .clk         (clk),
        .rst_n       (rst_n),
        .nes_data    (nes_data),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .nes_buttons (nes_buttons)
    );

    snes_pmod_receiver u_snes_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .pmod_data  (pmod_data),
        .pmod_clk   (pmod_clk),
        .pmod_latch (pmod_latch),
        .frame      (frame)
    );

    snes_frame_decoder u_snes_dec (
        .frame        (frame),
        .snes_buttons (snes_buttons),
        .is_present   (is_present)
    );

    // snes wins whenever a pad answers on the pmod
    // nes bits: a b select start up down left right from bit 7
    // snes bits: b y select start up down left right a x l r from bit 11
    assign a      = is_present ? snes_buttons[3]  : nes_buttons[7];
    assign b      = is_present ? snes_buttons[11] : nes_buttons[6];
    assign select = is_present ? snes_buttons[9]  : nes_buttons[5];
    assign start  = is_present ? snes_buttons[8]  : nes_buttons[4];
    assign up     = is_present ? snes_buttons[7]  : nes_buttons[3];
    assign down   = is_present ? snes_buttons[6]  : nes_buttons[2];
    assign left   = is_present ? snes_buttons[5]  : nes_buttons[1];
    assign right  = is_present ? snes_buttons[4]  : nes_buttons[0];

    // nes pad has no x y l r
    assign x = is_present & snes_buttons[2];
    assign y = is_present & snes_buttons[10];
    assign l = is_present & snes_buttons[1];
    assign r = is_present & snes_buttons[0];

    assign snes_active = is_present;

endmodule

`default_nettype wire

//--- hw/nes_poller.sv
// nes pad protocol engine, pulses latch, clocks out the seven later bits, samples eight buttons
`default_nettype none

module nes_poller #(
    parameter gamepad_pkg::cycle_count_t latch_cycles = gamepad_pkg::LATCH_CYCLES_DEFAULT,
    parameter gamepad_pkg::cycle_count_t half_cycles  = gamepad_pkg::HALF_CYCLES_DEFAULT
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      nes_data,     // active low from the pad
    output logic                      nes_latch,    // to pad
    output logic                      nes_clk,      // to pad
    output gamepad_pkg::nes_buttons_t nes_buttons   // pressed = 1
);

    // index into nes_buttons for the shifted bits
    localparam int IDX_BITS = $clog2(gamepad_pkg::NES_BITS);

    // b is the first bit behind a, right is bit 0
    localparam logic [IDX_BITS-1:0] FIRST_SHIFT_IDX =
        IDX_BITS'(gamepad_pkg::NES_BITS - 2);

    // a sits at the msb
    localparam int A_IDX = gamepad_pkg::NES_BITS - 1;

    gamepad_pkg::nes_state_t   state;
    gamepad_pkg::cycle_count_t count;      // cycles spent in current state or slot
    logic [IDX_BITS-1:0]       bit_idx;    // button taken by the current read_shift slot

    // frame = (L+1) latch + (H+1) read_a + 7 * (L+1) clock slots
    // latch and clock are registered from the state, so both lag it by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= gamepad_pkg::latch_pulse;
            count       <= '0;
            bit_idx     <= FIRST_SHIFT_IDX;
            nes_latch   <= 1'b0;
            nes_clk     <= 1'b0;
            nes_buttons <= '0;                       // all released
        end else begin
            // defaults, overridden per state
            count     <= count + 1'b1;
            nes_latch <= 1'b0;
            nes_clk   <= 1'b0;

            case (state)
                gamepad_pkg::latch_pulse: begin
                    nes_latch <= 1'b1;               // pad loads its buttons while high
                    if (count == latch_cycles) begin
                        count <= '0;
                        state <= gamepad_pkg::read_a;
                    end
                end

                gamepad_pkg::read_a: begin
                    // a shows up on the pin as soon as latch is seen, no clock needed
                    if (count == '0) begin
                        nes_buttons[A_IDX] <= ~nes_data;
                    end

                    if (count == half_cycles) begin
                        count   <= '0;
                        bit_idx <= FIRST_SHIFT_IDX;
                        state   <= gamepad_pkg::read_shift;
                    end
                end

                gamepad_pkg::read_shift: begin
                    // clock high in the first half of the slot, pad shifts on its rise
                    nes_clk <= (count <= half_cycles);

                    // sample late in the high phase, data long settled
                    if (count == half_cycles) begin
                        nes_buttons[bit_idx] <= ~nes_data;
                    end

                    if (count == latch_cycles) begin
                        count <= '0;
                        if (bit_idx == '0) begin
                            state <= gamepad_pkg::latch_pulse;  // right done, next frame
                        end else begin
                            bit_idx <= bit_idx - 1'b1;
                        end
                    end
                end

                default: begin
                    // unreachable encoding, restart the frame
                    count <= '0;
                    state <= gamepad_pkg::latch_pulse;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/snes_frame_decoder.sv
// snes frame decode, presence check and glitch filter on a captured pmod frame
`default_nettype none

module snes_frame_decoder (
    input  gamepad_pkg::snes_frame_t frame,
    output gamepad_pkg::snes_frame_t snes_buttons,  // frame order, pressed = 1
    output logic                     is_present
);

    // wide enough to count every bit of the frame
    localparam int CNT_BITS = $clog2(gamepad_pkg::SNES_BITS + 1);

    logic                     frame_empty;
    gamepad_pkg::snes_frame_t button_data;
    logic [CNT_BITS-1:0]      pressed_cnt;
    logic                     too_many;

    // idle pmod line shifts in ones
    assign frame_empty = (frame == gamepad_pkg::SNES_NONE);
    assign is_present  = ~frame_empty;

    assign button_data = frame_empty ? '0 : frame;

    // popcount of pressed buttons
    always_comb begin
        pressed_cnt = '0;
        for (int i = 0; i < gamepad_pkg::SNES_BITS; i++) begin
            pressed_cnt = pressed_cnt + CNT_BITS'(button_data[i]);
        end
    end

    // every other pmod frame comes back garbled with many bits set
    assign too_many = (pressed_cnt > CNT_BITS'(gamepad_pkg::SNES_MAX_PRESSED));

    assign snes_buttons = too_many ? '0 : button_data;  // drop the whole frame

endmodule

`default_nettype wire

//--- hw/snes_pmod_receiver.sv
// snes gamepad pmod input stage, syncs the three pmod lines and captures a 12-bit frame
`default_nettype none

module snes_pmod_receiver (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pmod_data,    // async, driven by the pmod mcu
    input  logic                     pmod_clk,     // async
    input  logic                     pmod_latch,   // async
    output gamepad_pkg::snes_frame_t frame         // last complete frame, all ones = no pad
);

    // two-flop synchronizers, bit 1 is the safe side
    logic [1:0] data_sync;
    logic [1:0] clk_sync;
    logic [1:0] latch_sync;

    // previous synced levels for edge detect
    logic clk_prev;
    logic latch_prev;

    logic clk_rise;
    logic latch_rise;

    gamepad_pkg::snes_frame_t shift_reg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_sync  <= '0;
            clk_sync   <= '0;
            latch_sync <= '0;
            clk_prev   <= 1'b0;
            latch_prev <= 1'b0;
        end else begin
            data_sync  <= {data_sync[0], pmod_data};
            clk_sync   <= {clk_sync[0], pmod_clk};
            latch_sync <= {latch_sync[0], pmod_latch};
            clk_prev   <= clk_sync[1];
            latch_prev <= latch_sync[1];
        end
    end

    assign clk_rise   = clk_sync[1] & ~clk_prev;
    assign latch_rise = latch_sync[1] & ~latch_prev;

    // data runs through the same two flops as clk, so it lines up with clk_rise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_reg <= gamepad_pkg::SNES_NONE;
            frame     <= gamepad_pkg::SNES_NONE;   // reads as not present until a frame lands
        end else begin
            if (clk_rise) begin
                // msb first, b ends at bit 11
                shift_reg <= {shift_reg[gamepad_pkg::SNES_BITS-2:0], data_sync[1]};
            end
            if (latch_rise) begin
                frame <= shift_reg;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim.f
hw/gamepad_pkg.sv
hw/nes_poller.sv
hw/snes_pmod_receiver.sv
hw/snes_frame_decoder.sv
hw/gamepad_top.sv
testbench/tb_pad_models.sv
testbench/tb_gamepad_top.sv

//--- testbench/tb_gamepad_top.sv
// testbench for gamepad_top where pad models drive the dut and a checker compares against a reference
`default_nettype none

module tb_gamepad_top;

    // short nes timing for simulation
    localparam gamepad_pkg::cycle_count_t LATCH_CYCLES = 11'd24;
    localparam gamepad_pkg::cycle_count_t HALF_CYCLES  = 11'd12;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;       // after the rising edge
    localparam int RESET_CYCLES = 16;
    localparam int LATCH_HIGH   = LATCH_CYCLES + 1;
    localparam int FRAME_CYCLES = LATCH_HIGH + (HALF_CYCLES + 1) + 7 * LATCH_HIGH;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;
    localparam logic [31:0] RAND_SEED = 32'h8218_bc1d;

    logic clk;
    logic rst_n;
    logic nes_data;
    logic nes_latch;
    logic nes_clk;
    logic pmod_data;
    logic pmod_clk;
    logic pmod_latch;
    logic a, b, select, start, up, down, left, right;
    logic x, y, l, r;
    logic snes_active;

    gamepad_pkg::nes_buttons_t nes_pattern;   // buttons held on the nes pad
    gamepad_pkg::snes_frame_t  last_frame;    // last frame sent on the pmod
    int   error_count;
    int   check_count;
    event check_now;                          // stimulus asks for a compare

    always #(CLK_PERIOD / 2) clk = ~clk;

    gamepad_top #(
        .latch_cycles (LATCH_CYCLES),
        .half_cycles  (HALF_CYCLES)
    ) uut (
        .clk (clk), .rst_n (rst_n),
        .nes_data (nes_data), .nes_latch (nes_latch), .nes_clk (nes_clk),
        .pmod_data (pmod_data), .pmod_clk (pmod_clk), .pmod_latch (pmod_latch),
        .a (a), .b (b), .select (select), .start (start),
        .up (up), .down (down), .left (left), .right (right),
        .x (x), .y (y), .l (l), .r (r),
        .snes_active (snes_active)
    );

    nes_pad_model #(.drive_delay(DRIVE_DELAY)) nes_pad (
        .nes_latch (nes_latch), .nes_clk (nes_clk), .pattern (nes_pattern), .nes_data (nes_data)
    );

    snes_pmod_sender #(.drive_delay(DRIVE_DELAY), .phase_clocks(4)) pmod_tx (
        .clk (clk), .pmod_data (pmod_data), .pmod_clk (pmod_clk), .pmod_latch (pmod_latch)
    );

    function automatic int pressed_count(input gamepad_pkg::snes_frame_t f);
        int n;
        n = 0;
        for (int k = 0; k < gamepad_pkg::SNES_BITS; k++) begin
            if (f[k]) n++;
        end
        return n;
    endfunction

    // {a, b, select, start, up, down, left, right, x, y, l, r, snes_active}
    function automatic logic [12:0] expected_outputs(input gamepad_pkg::nes_buttons_t nes,
                                                     input gamepad_pkg::snes_frame_t frame);
        logic [gamepad_pkg::SNES_BITS-1:0] serial;   // serial[k] = k-th bit on the wire
        for (int k = 0; k < gamepad_pkg::SNES_BITS; k++) begin
            serial[k] = frame[gamepad_pkg::SNES_BITS-1-k];
        end
        if (&frame) begin
            return {nes, 4'b0000, 1'b0};              // no snes pad and nes has no x y l r
        end
        if (pressed_count(frame) > gamepad_pkg::SNES_MAX_PRESSED) begin
            return {12'b0, 1'b1};                     // glitched frame with the pad still present
        end
        // wire order b y select start up down left right a x l r
        return {serial[8], serial[0], serial[2], serial[3], serial[4], serial[5],
                serial[6], serial[7], serial[9], serial[1], serial[10], serial[11], 1'b1};
    endfunction

    function automatic string output_name(input int idx);
        case (idx)
            12:      return "a";
            11:      return "b";
            10:      return "select";
            9:       return "start";
            8:       return "up";
            7:       return "down";
            6:       return "left";
            5:       return "right";
            4:       return "x";
            3:       return "y";
            2:       return "l";
            1:       return "r";
            default: return "snes_active";
        endcase
    endfunction

    task automatic expect_bit(input string name, input logic got, input logic want);
        check_count++;
        assert (got === want) else begin
            error_count++;
            $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic expect_count(input string name, input int got, input int want);
        check_count++;
        assert (got == want) else begin
            error_count++;
            $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, want);
        end
    endtask

    // compare all 13 outputs on request
    always @(check_now) begin : compare_outputs
        logic [12:0] got_vec;
        logic [12:0] want_vec;
        got_vec  = {a, b, select, start, up, down, left, right, x, y, l, r, snes_active};
        want_vec = expected_outputs(nes_pattern, last_frame);
        for (int i = 12; i >= 0; i--) begin
            expect_bit(output_name(i), got_vec[i], want_vec[i]);
        end
    end

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timeout at time %0t: %s did not happen within %0d cycles",
                 $time, what, WAIT_LIMIT);
        finish_run();
    endtask

    task automatic step();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic wait_latch(input logic level);
        int waited;
        waited = 0;
        while (nes_latch !== level && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (nes_latch !== level) report_timeout("nes_latch level change");
    endtask

    // one full latch pulse plus the clock slots up to the next one
    task automatic check_nes_shape();
        int   high_cycles;
        int   clk_pulses;
        int   waited;
        logic clk_prev;
        wait_latch(1'b0);                         // skip a pulse already under way
        wait_latch(1'b1);
        high_cycles = 0;
        while (nes_latch === 1'b1 && high_cycles <= WAIT_LIMIT) begin
            high_cycles++;
            step();
        end
        if (high_cycles > WAIT_LIMIT) report_timeout("nes_latch fall");
        clk_pulses = 0;
        clk_prev   = nes_clk;
        waited     = 0;
        while (nes_latch !== 1'b1 && waited < WAIT_LIMIT) begin
            if (nes_clk === 1'b1 && clk_prev !== 1'b1) clk_pulses++;   // rising edge
            clk_prev = nes_clk;
            step();
            waited++;
        end
        if (nes_latch !== 1'b1) report_timeout("next nes_latch rise");
        expect_count("nes_latch high cycles", high_cycles, LATCH_HIGH);
        expect_count("nes_clk pulses per frame", clk_pulses, 7);
    endtask

    // new nes pattern loaded cleanly by the next two latch pulses
    task automatic change_nes_pattern(input gamepad_pkg::nes_buttons_t p);
        wait_latch(1'b0);
        nes_pattern = p;
        repeat (2) begin
            wait_latch(1'b1);
            wait_latch(1'b0);
        end
        -> check_now;
        step();
    endtask

    task automatic send_and_check(input gamepad_pkg::snes_frame_t f);
        pmod_tx.send_frame(f);
        last_frame = f;
        -> check_now;
        step();
    endtask

    // one or two pressed buttons
    function automatic gamepad_pkg::snes_frame_t few_pressed_frame();
        gamepad_pkg::snes_frame_t f;
        f = '0;
        f[$urandom_range(gamepad_pkg::SNES_BITS - 1, 0)] = 1'b1;
        if ($urandom_range(1, 0) == 1) f[$urandom_range(gamepad_pkg::SNES_BITS - 1, 0)] = 1'b1;
        return f;
    endfunction

    // at least three pressed and never all ones
    function automatic gamepad_pkg::snes_frame_t many_pressed_frame();
        gamepad_pkg::snes_frame_t f;
        logic [31:0]              rnd;
        int                       base;
        rnd  = $urandom;
        base = $urandom_range(gamepad_pkg::SNES_BITS - 1, 0);
        f    = rnd[gamepad_pkg::SNES_BITS-1:0];
        f[(base + 4) % gamepad_pkg::SNES_BITS] = 1'b1;
        f[(base + 8) % gamepad_pkg::SNES_BITS] = 1'b1;
        f[base] = 1'b1;
        if (&f) f[base] = 1'b0;                  // 11 left is still a glitch
        return f;
    endfunction

    initial begin : stimulus
        logic [31:0] rnd;
        int          seed_value;
        clk         = 1'b0;
        rst_n       = 1'b0;
        nes_pattern = '0;
        last_frame  = '1;                         // nothing sent yet
        error_count = 0;
        check_count = 0;
        seed_value  = $urandom(RAND_SEED);

        // all outputs idle through reset
        repeat (RESET_CYCLES) begin
            step();
            expect_bit("nes_latch", nes_latch, 1'b0);
            expect_bit("nes_clk", nes_clk, 1'b0);
            -> check_now;
        end
        rst_n = 1'b1;
        repeat (LATCH_CYCLES) begin               // buttons released until read_a
            step();
            -> check_now;
        end

        // protocol shape on two frames
        repeat (2) check_nes_shape();

        // nes only
        change_nes_pattern(8'hff);
        repeat (6) begin
            rnd = $urandom;
            change_nes_pattern(rnd[7:0]);
        end

        // snes present with valid frames
        send_and_check(12'h000);                  // present with nothing pressed
        send_and_check(12'b0100_0000_0100);       // y, x
        send_and_check(12'b0000_0000_0011);       // l, r
        repeat (8) send_and_check(few_pressed_frame());

        // glitched frames mixed with valid ones
        repeat (6) begin
            send_and_check(many_pressed_frame());
            send_and_check(few_pressed_frame());
        end

        // pad unplugged so outputs fall back to nes
        send_and_check('1);
        rnd = $urandom;
        change_nes_pattern(rnd[7:0]);

        finish_run();
    end

endmodule

`default_nettype wire

//--- testbench/tb_pad_models.sv
// behavioral pad models for the gamepad testbench, an nes shift-register pad and an snes pmod sender
`default_nettype none

// nes pad, 4021-style shift register with active low data
module nes_pad_model #(
    parameter int drive_delay = 2
) (
    input  logic                      nes_latch,
    input  logic                      nes_clk,
    input  gamepad_pkg::nes_buttons_t pattern,    // pressed = 1, a at bit 7
    output logic                      nes_data    // active low, to the dut
);

    gamepad_pkg::nes_buttons_t shift_reg = '0;
    logic                      level;
    logic                      data_q = 1'b1;     // released until the first load

    // parallel load on latch, one bit per clock rise after that
    always @(posedge nes_latch or posedge nes_clk) begin
        if (nes_latch) begin
            shift_reg <= pattern;
        end else begin
            shift_reg <= {shift_reg[gamepad_pkg::NES_BITS-2:0], 1'b0};  // zeros read as released
        end
    end

    // a shows on the pin while latch is high
    assign level = (nes_latch === 1'b1) ? ~pattern[gamepad_pkg::NES_BITS-1]
                                         : ~shift_reg[gamepad_pkg::NES_BITS-1];

    // pad output lags its clock edge a little
    always @(level) begin
        data_q <= #(drive_delay) level;
    end

    assign nes_data = data_q;

endmodule

// snes pmod sender, shifts a frame out msb first and pulses latch after it
module snes_pmod_sender #(
    parameter int drive_delay  = 2,
    parameter int phase_clocks = 4     // system clocks per pmod clock phase
) (
    input  logic clk,
    output logic pmod_data,
    output logic pmod_clk,
    output logic pmod_latch
);

    initial begin
        pmod_data  = 1'b1;             // idle line reads high
        pmod_clk   = 1'b0;
        pmod_latch = 1'b0;
    end

    // n rising edges, then the drive delay
    task automatic hold_clocks(input int n);
        repeat (n) @(posedge clk);
        #(drive_delay);
    endtask

    // b goes out first and lands at frame bit 11
    task automatic send_frame(input gamepad_pkg::snes_frame_t f);
        hold_clocks(1);
        for (int i = gamepad_pkg::SNES_BITS - 1; i >= 0; i--) begin
            pmod_clk  = 1'b0;
            pmod_data = f[i];          // set up during the low phase
            hold_clocks(phase_clocks);
            pmod_clk  = 1'b1;          // receiver shifts on this rise
            hold_clocks(phase_clocks);
        end
        pmod_clk   = 1'b0;
        pmod_latch = 1'b1;             // capture the shifted frame
        hold_clocks(phase_clocks);
        pmod_latch = 1'b0;
        hold_clocks(phase_clocks);     // covers the 3 cycle capture delay
    endtask

endmodule

`default_nettype wire
